// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert --timing -j 0
TOP       := muldiv_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+100

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_FLAGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
hdl/muldiv_pkg.sv
hdl/muldiv_dispatch.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/muldiv_result.sv
hdl/muldiv_top.sv
test/muldiv_props.sv
test/muldiv_tb.sv

// File: hdl/div_unit.sv
`timescale 1ns/1ps

module div_unit import muldiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  div_op_e         req_op_i,
  input  logic            req_word_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,

  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o
);

  localparam int ITER_BITS = $clog2(MUL_ITER_D + 1);

  logic                 is_unsigned;
  logic                 a_sign, b_sign;
  logic [XLEN-1:0]      a_ext, b_ext;
  logic [XLEN-1:0]      a_mag, b_mag;
  logic [XLEN-1:0]      a_rev;

  // Iterations left, zero while idle
  logic [ITER_BITS-1:0] iter_q;
  logic                 busy, start, last;

  logic [XLEN-1:0]      a_q, b_q;
  logic [XLEN-1:0]      rem_q, quo_q;
  logic                 quo_neg_q, rem_neg_q;
  logic                 word_q, use_rem_q;

  logic [XLEN-1:0]      rem_shift, rem_next, quo_next;
  logic                 rem_fits;
  logic [XLEN-1:0]      result;

  assign is_unsigned = req_op_i[0];

  // Word operands are extended first so both modes share the sign logic
  always_comb begin
    if (req_word_i) begin
      a_ext = {{32{!is_unsigned && operand_a_i[31]}}, operand_a_i[31:0]};
      b_ext = {{32{!is_unsigned && operand_b_i[31]}}, operand_b_i[31:0]};
    end else begin
      a_ext = operand_a_i;
      b_ext = operand_b_i;
    end
    a_sign = !is_unsigned && a_ext[XLEN-1];
    b_sign = !is_unsigned && b_ext[XLEN-1];
    a_mag  = a_sign ? -a_ext : a_ext;
    b_mag  = b_sign ? -b_ext : b_ext;

    // Dividend enters the remainder MSB first
    a_rev = '0;
    if (req_word_i) begin
      a_rev[31:0] = {<<{a_mag[31:0]}};
    end else begin
      a_rev = {<<{a_mag}};
    end
  end

  assign busy        = iter_q != '0;
  assign start       = !busy && req_valid_i;
  assign last        = iter_q == ITER_BITS'(1);
  assign req_ready_o = !busy;

  // One restoring step
  always_comb begin
    rem_shift = {rem_q[XLEN-2:0], a_q[0]};
    rem_fits  = rem_shift >= b_q;
    rem_next  = rem_fits ? rem_shift - b_q : rem_shift;
    quo_next  = {quo_q[XLEN-2:0], rem_fits};
    if (use_rem_q) begin
      result = rem_neg_q ? -rem_next : rem_next;
    end else begin
      result = quo_neg_q ? -quo_next : quo_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iter_q       <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      if (start) begin
        iter_q <= req_word_i ? ITER_BITS'(MUL_ITER_W) : ITER_BITS'(MUL_ITER_D);
      end else if (busy) begin
        iter_q <= iter_q - ITER_BITS'(1);
      end
      resp_valid_o <= busy && last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      a_q       <= a_rev;
      b_q       <= b_mag;
      rem_q     <= '0;
      quo_q     <= '0;
      // Divide by zero already yields all ones, keep it unsigned
      quo_neg_q <= (a_sign ^ b_sign) && (b_mag != '0);
      rem_neg_q <= a_sign;
      word_q    <= req_word_i;
      use_rem_q <= req_op_i[1];
    end else if (busy) begin
      a_q   <= a_q >> 1;
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
    if (busy && last) begin
      resp_value_o <= word_q ? {{32{result[31]}}, result[31:0]} : result;
    end
  end

endmodule

// File: hdl/mul_unit.sv
`timescale 1ns/1ps

module mul_unit import muldiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  mul_op_e         req_op_i,
  input  logic            req_word_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,

  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o
);

  // One 17x17 signed MAC with registered inputs, so the first busy cycle only
  // fetches limbs. MULW takes 4 cycles, MUL 11 and the high products 17

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e          state_q, state_d;
  logic [4:0]      step_q, step_d;
  logic [3:0]      acc_step;
  logic [1:0]      a_idx, b_idx;

  // Operands extended to 65 bits
  logic [XLEN:0]   op_a_q, op_b_q;
  logic            low_only_q;
  logic            word_q;

  logic [16:0]     mac_a_q, mac_b_q;
  logic [36:0]     accum_q, accum_d;
  logic [36:0]     mac_prod;

  logic            valid_d;
  logic [XLEN-1:0] value_d;

  // Limbs 0 to 2 are 16 bits wide and unsigned, limb 3 carries the sign
  function automatic logic [16:0] limb(logic [XLEN:0] op, logic [1:0] idx);
    unique case (idx)
      2'd0:    limb = {1'b0, op[15:0]};
      2'd1:    limb = {1'b0, op[31:16]};
      2'd2:    limb = {1'b0, op[47:32]};
      default: limb = op[64:48];
    endcase
  endfunction

  assign req_ready_o = state_q == IDLE;
  assign mac_prod    = signed'(accum_q) + signed'(mac_a_q) * signed'(mac_b_q);

  // Limb pair fetched in each step, walked column by column
  always_comb begin
    unique case (step_q[3:0])
      4'd0:  {a_idx, b_idx} = {2'd0, 2'd0};
      4'd1:  {a_idx, b_idx} = {2'd1, 2'd0};
      4'd2:  {a_idx, b_idx} = {2'd0, 2'd1};
      4'd3:  {a_idx, b_idx} = {2'd0, 2'd2};
      4'd4:  {a_idx, b_idx} = {2'd1, 2'd1};
      4'd5:  {a_idx, b_idx} = {2'd2, 2'd0};
      4'd6:  {a_idx, b_idx} = {2'd3, 2'd0};
      4'd7:  {a_idx, b_idx} = {2'd2, 2'd1};
      4'd8:  {a_idx, b_idx} = {2'd1, 2'd2};
      4'd9:  {a_idx, b_idx} = {2'd0, 2'd3};
      4'd10: {a_idx, b_idx} = {2'd1, 2'd3};
      4'd11: {a_idx, b_idx} = {2'd2, 2'd2};
      4'd12: {a_idx, b_idx} = {2'd3, 2'd1};
      4'd13: {a_idx, b_idx} = {2'd3, 2'd2};
      4'd14: {a_idx, b_idx} = {2'd2, 2'd3};
      4'd15: {a_idx, b_idx} = {2'd3, 2'd3};
    endcase
  end

  always_comb begin
    state_d  = state_q;
    step_d   = step_q;
    accum_d  = accum_q;
    value_d  = resp_value_o;
    valid_d  = 1'b0;
    // The MAC works on the pair fetched one cycle earlier
    acc_step = 4'(step_q - 5'd1);

    unique case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = BUSY;
          step_d  = '0;
          accum_d = '0;
        end
      end
      BUSY: begin
        step_d = step_q + 5'd1;
        if (step_q != '0) begin
          accum_d = mac_prod;
          case (acc_step)
            4'd0: begin
              value_d[15:0] = mac_prod[15:0];
              accum_d       = {{16{mac_prod[36]}}, mac_prod[36:16]};
            end
            4'd2: begin
              // Also the sign-extended MULW result
              value_d[63:16] = {{32{mac_prod[15]}}, mac_prod[15:0]};
              accum_d        = {{16{mac_prod[36]}}, mac_prod[36:16]};
              if (word_q) begin
                valid_d = 1'b1;
                state_d = IDLE;
              end
            end
            4'd5: begin
              value_d[47:32] = mac_prod[15:0];
              accum_d        = {{16{mac_prod[36]}}, mac_prod[36:16]};
            end
            4'd9: begin
              value_d[63:48] = mac_prod[15:0];
              accum_d        = {{16{mac_prod[36]}}, mac_prod[36:16]};
              if (low_only_q) begin
                valid_d = 1'b1;
                state_d = IDLE;
              end
            end
            // High half columns overwrite the low result
            4'd12: begin
              value_d[15:0] = mac_prod[15:0];
              accum_d       = {{16{mac_prod[36]}}, mac_prod[36:16]};
            end
            4'd14: begin
              value_d[31:16] = mac_prod[15:0];
              accum_d        = {{16{mac_prod[36]}}, mac_prod[36:16]};
            end
            4'd15: begin
              value_d[63:32] = mac_prod[31:0];
              valid_d        = 1'b1;
              state_d        = IDLE;
            end
            default: ;
          endcase
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      step_q       <= '0;
      resp_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      step_q       <= step_d;
      resp_valid_o <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      op_a_q     <= {req_op_i != MUL_OP_MULHU && operand_a_i[XLEN-1], operand_a_i};
      op_b_q     <= {!req_op_i[1] && operand_b_i[XLEN-1], operand_b_i};
      low_only_q <= req_op_i == MUL_OP_MUL;
      word_q     <= req_word_i;
    end
    mac_a_q      <= limb(op_a_q, a_idx);
    mac_b_q      <= limb(op_b_q, b_idx);
    accum_q      <= accum_d;
    resp_value_o <= value_d;
  end

endmodule

// File: hdl/muldiv_dispatch.sv
`timescale 1ns/1ps

module muldiv_dispatch import muldiv_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,

  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  md_op_u  req_op_i,

  // Completion from the result stage
  input  logic    done_i,

  output logic    mul_valid_o,
  output logic    div_valid_o,
  output mul_op_e mul_op_o,
  output div_op_e div_op_o
);

  logic busy_q;
  logic accept;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && !busy_q;

  // Top funct3 bit picks the engine
  assign mul_valid_o = accept && !req_op_i.mul.is_div;
  assign div_valid_o = accept && req_op_i.div.is_div;

  assign mul_op_o = req_op_i.mul.op;
  assign div_op_o = req_op_i.div.op;

  // Only one request in flight since both engines share the result stage
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (done_i) begin
      busy_q <= 1'b0;
    end
  end

endmodule

// File: hdl/muldiv_pkg.sv
package muldiv_pkg;

  // Data path width
  localparam int XLEN = 64;

  // Width of the funct3 field that selects the operation
  localparam int MD_FUNCT_W = 3;

  // Divider iteration counts for word and double-word operands
  localparam int MUL_ITER_W = 32;
  localparam int MUL_ITER_D = 64;

  // Bit 1 set makes operand b unsigned, MULHU also clears the sign of a
  typedef enum logic [1:0] {
    MUL_OP_MUL    = 2'b00,
    MUL_OP_MULH   = 2'b01,
    MUL_OP_MULHSU = 2'b10,
    MUL_OP_MULHU  = 2'b11
  } mul_op_e;

  // Bit 0 selects unsigned, bit 1 selects the remainder
  typedef enum logic [1:0] {
    DIV_OP_DIV  = 2'b00,
    DIV_OP_DIVU = 2'b01,
    DIV_OP_REM  = 2'b10,
    DIV_OP_REMU = 2'b11
  } div_op_e;

  typedef struct packed {
    logic    is_div;
    mul_op_e op;
  } md_mul_t;

  typedef struct packed {
    logic    is_div;
    div_op_e op;
  } md_div_t;

  // The RV64M funct3, read as either engine's operation
  typedef union packed {
    md_mul_t mul;
    md_div_t div;
  } md_op_u;

endpackage

// File: hdl/muldiv_result.sv
`timescale 1ns/1ps

module muldiv_result import muldiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic            mul_valid_i,
  input  logic [XLEN-1:0] mul_value_i,
  input  logic            div_valid_i,
  input  logic [XLEN-1:0] div_value_i,

  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o,
  output logic            done_o
);

  // Frees the dispatcher on the same edge the response is registered
  assign done_o = mul_valid_i | div_valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= done_o;
    end
  end

  // Value held until the next response
  always_ff @(posedge clk_i) begin
    if (done_o) begin
      resp_value_o <= mul_valid_i ? mul_value_i : div_value_i;
    end
  end

endmodule

// File: hdl/muldiv_top.sv
`timescale 1ns/1ps

module muldiv_top import muldiv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  md_op_u          req_op_i,
  input  logic            req_word_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,

  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_value_o
);

  logic            mul_valid, div_valid;
  mul_op_e         mul_op;
  div_op_e         div_op;
  logic            mul_resp_valid, div_resp_valid;
  logic [XLEN-1:0] mul_resp_value, div_resp_value;
  logic            done;

  muldiv_dispatch u_dispatch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .done_i      (done),
    .mul_valid_o (mul_valid),
    .div_valid_o (div_valid),
    .mul_op_o    (mul_op),
    .div_op_o    (div_op)
  );

  // Engine ready is implied by the dispatcher busy flag
  mul_unit u_mul (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (mul_op),
    .req_word_i   (req_word_i),
    .req_valid_i  (mul_valid),
    .req_ready_o  (),
    .resp_valid_o (mul_resp_valid),
    .resp_value_o (mul_resp_value)
  );

  div_unit u_div (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .req_op_i     (div_op),
    .req_word_i   (req_word_i),
    .req_valid_i  (div_valid),
    .req_ready_o  (),
    .resp_valid_o (div_resp_valid),
    .resp_value_o (div_resp_value)
  );

  muldiv_result u_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mul_valid_i  (mul_resp_valid),
    .mul_value_i  (mul_resp_value),
    .div_valid_i  (div_resp_valid),
    .div_value_i  (div_resp_value),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o),
    .done_o       (done)
  );

endmodule

// File: test/muldiv_props.sv
`timescale 1ns/1ps

module muldiv_props import muldiv_pkg::*; (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic req_ready_i,
  input logic resp_valid_i,
  input logic mul_resp_valid_i,
  input logic div_resp_valid_i
);

  // Read by the testbench after each cycle
  int unsigned fail_count = 0;

  logic       pending_q;
  logic [6:0] wait_q;
  logic       accept;

  assign accept = req_valid_i && req_ready_i;

  // Age of the request in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      wait_q    <= '0;
    end else if (accept) begin
      pending_q <= 1'b1;
      wait_q    <= '0;
    end else if (resp_valid_i) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      wait_q <= wait_q + 7'd1;
    end
  end

  single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |=> !resp_valid_i)
    else begin
      fail_count++;
      $error("resp_valid_o high for two cycles in a row");
    end

  // Ready stays low until it returns together with the response
  ready_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q |-> (req_ready_i == resp_valid_i))
    else begin
      fail_count++;
      $error("req_ready_o out of step with the request in flight");
    end

  // Shared result stage takes one engine response at a time
  one_engine: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mul_resp_valid_i && div_resp_valid_i))
    else begin
      fail_count++;
      $error("both engines responded on the same edge");
    end

  latency_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q |-> wait_q <= 7'(MUL_ITER_D + 1))
    else begin
      fail_count++;
      $error("no response within the longest operation latency");
    end

endmodule

bind muldiv_top muldiv_props u_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .req_valid_i      (req_valid_i),
  .req_ready_i      (req_ready_o),
  .resp_valid_i     (resp_valid_o),
  .mul_resp_valid_i (mul_resp_valid),
  .div_resp_valid_i (div_resp_valid)
);

// File: test/muldiv_tb.sv
`timescale 1ns/1ps

module muldiv_tb import muldiv_pkg::*; ();

  localparam int TIMEOUT = 100;

  logic            clk_i;
  logic            rst_ni;
  logic            req_valid_i;
  logic            req_ready_o;
  md_op_u          req_op_i;
  logic            req_word_i;
  logic [XLEN-1:0] operand_a_i;
  logic [XLEN-1:0] operand_b_i;
  logic            resp_valid_o;
  logic [XLEN-1:0] resp_value_o;

  integer          seed = 33;
  logic [XLEN-1:0] expected_q[$];
  int              sent_count = 0;
  int              recv_count = 0;
  logic [XLEN-1:0] held_value;
  logic            have_held = 1'b0;

  // Includes a word minimum with junk in the upper half
  logic [XLEN-1:0] corners [6] = '{
    64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, 64'hFFFF_FFFF_FFFF_FFFF,
    64'h8000_0000_0000_0000, 64'h7FFF_FFFF_FFFF_FFFF, 64'h1234_5678_8000_0000
  };

  muldiv_top dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_word_i   (req_word_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .resp_valid_o (resp_valid_o),
    .resp_value_o (resp_value_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  function automatic logic [XLEN-1:0] sext_word(logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // Selector 0..3 high and low products, 4 MULW, 5..12 divides with word ops last
  function automatic void pick_op(int sel, output md_op_u op, output logic word);
    op   = '0;
    word = 1'b0;
    if (sel < 4) begin
      op.mul.op = mul_op_e'(2'(sel));
    end else if (sel == 4) begin
      op.mul.op = MUL_OP_MUL;
      word      = 1'b1;
    end else begin
      op.div.is_div = 1'b1;
      op.div.op     = div_op_e'(2'((sel - 5) % 4));
      word          = sel >= 9;
    end
  endfunction

  function automatic logic [XLEN-1:0] ref_muldiv(md_op_u op, logic word,
                                                 logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    logic [2*XLEN-1:0]        wide_a, wide_b, prod;
    logic signed [2*XLEN-1:0] num, den, quo, rem;
    logic                     a_signed, b_signed, want_rem;
    logic [XLEN-1:0]          res;
    if (!op.mul.is_div) begin
      a_signed = op.mul.op != MUL_OP_MULHU;
      b_signed = op.mul.op == MUL_OP_MUL || op.mul.op == MUL_OP_MULH;
      wide_a   = {{XLEN{a_signed && a[XLEN-1]}}, a};
      wide_b   = {{XLEN{b_signed && b[XLEN-1]}}, b};
      prod     = wide_a * wide_b;
      res      = (op.mul.op == MUL_OP_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    end else begin
      a_signed = op.div.op == DIV_OP_DIV || op.div.op == DIV_OP_REM;
      want_rem = op.div.op == DIV_OP_REM || op.div.op == DIV_OP_REMU;
      if (word) begin
        num = {{96{a_signed && a[31]}}, a[31:0]};
        den = {{96{a_signed && b[31]}}, b[31:0]};
      end else begin
        num = {{XLEN{a_signed && a[XLEN-1]}}, a};
        den = {{XLEN{a_signed && b[XLEN-1]}}, b};
      end
      // Wide enough that the overflow case comes out right by itself
      if (den == 0) begin
        quo = '1;
        rem = num;
      end else begin
        quo = num / den;
        rem = num % den;
      end
      res = want_rem ? rem[XLEN-1:0] : quo[XLEN-1:0];
    end
    return word ? sext_word(res[31:0]) : res;
  endfunction

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [XLEN-1:0] actual, logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, actual, expected);
      abort_run();
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic send_request(md_op_u op, logic word, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    int waited;
    waited      = 0;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_word_i  = word;
    operand_a_i = a;
    operand_b_i = b;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #2;
      waited++;
      if (waited > TIMEOUT) begin
        $display("Request was not accepted within %0d cycles", TIMEOUT);
        abort_run();
      end
    end
    @(posedge clk_i);
    #2;
    expected_q.push_back(ref_muldiv(op, word, a, b));
    sent_count++;
  endtask

  task automatic release_request();
    req_valid_i = 1'b0;
  endtask

  task automatic wait_responses();
    int waited;
    waited = 0;
    while (recv_count != sent_count) begin
      @(posedge clk_i);
      #2;
      waited++;
      if (waited > TIMEOUT) begin
        $display("Response did not arrive within %0d cycles", TIMEOUT);
        abort_run();
      end
    end
  endtask

  // Responses checked in the middle of the cycle
  initial begin
    forever begin
      @(negedge clk_i);
      if (dut0.u_props.fail_count != 0) begin
        $display("A protocol assertion in muldiv_props failed");
        abort_run();
      end
      if (rst_ni && resp_valid_o) begin
        if (expected_q.size() == 0) begin
          $display("A response arrived with no request outstanding");
          abort_run();
        end
        check_value("resp_value_o", resp_value_o, expected_q.pop_front());
        held_value = resp_value_o;
        have_held  = 1'b1;
        recv_count++;
      end else if (have_held) begin
        check_value("resp_value_o (held)", resp_value_o, held_value);
      end
    end
  end

  initial begin
    md_op_u          op;
    logic            word;
    logic [XLEN-1:0] a, b;
    int              sel;

    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = '0;
    req_word_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    @(posedge clk_i);
    #2;
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("resp_valid_o", resp_valid_o, 1'b0);

    // Every operation on every corner pair, one request at a time
    for (int s = 0; s < 13; s++) begin
      pick_op(s, op, word);
      for (int i = 0; i < 6; i++) begin
        for (int j = 0; j < 6; j++) begin
          send_request(op, word, corners[i], corners[j]);
          release_request();
          wait_responses();
        end
      end
    end

    // Random operands, divisor shortened now and then for real quotients
    repeat (400) begin
      sel = int'($unsigned($random(seed)) % 13);
      pick_op(sel, op, word);
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      b = b >> ($unsigned($random(seed)) % 64);
      send_request(op, word, a, b);
      release_request();
      wait_responses();
    end

    // Valid held high, multiply and divide taking turns
    for (int n = 0; n < 60; n++) begin
      if (n % 2 == 0) begin
        sel = int'($unsigned($random(seed)) % 5);
      end else begin
        sel = 5 + int'($unsigned($random(seed)) % 8);
      end
      pick_op(sel, op, word);
      a = {$random(seed), $random(seed)};
      b = {$random(seed), $random(seed)};
      b = b >> ($unsigned($random(seed)) % 64);
      send_request(op, word, a, b);
    end
    release_request();
    wait_responses();
    repeat (5) @(posedge clk_i);
    #2;

    if (recv_count == sent_count && dut0.u_props.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("Response count or assertion status wrong at the end of the run");
      abort_run();
    end
  end

endmodule
